/* net_cfg_pkg.sv */
package net_cfg_pkg;

    // Own station
    localparam logic [47:0] LOCAL_MAC  = 48'h11_11_11_11_11_11;
    localparam logic [31:0] LOCAL_IP   = 32'hC0_A8_01_6E;
    localparam logic [15:0] LOCAL_PORT = 16'h8080;

    // Fixed peer
    localparam logic [31:0] DEST_IP   = 32'hC0_A8_01_69;
    localparam logic [15:0] DEST_PORT = 16'h8080;

    // Link-up timing, scaled down from the board values
    localparam logic [15:0] LINK_WAIT_CYCLES   = 16'd2000;
    localparam logic [15:0] ARP_TIMEOUT_CYCLES = 16'd2000;

    // Payload buffer
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_AW    = 6;

    // Source pauses below this many free entries
    localparam logic [FIFO_AW:0] READ_MARGIN = (FIFO_AW + 1)'(4);

    // Frame sizes in bytes
    localparam logic [15:0] ARP_FRAME_BYTES = 16'd42;
    localparam logic [15:0] UDP_HDR_BYTES   = 16'd42;
    localparam logic [15:0] INDEX_BYTES     = 16'd2;

endpackage : net_cfg_pkg

/* frame_pkg.sv */
package frame_pkg;

    // One byte on the MAC stream
    typedef struct packed {
        logic       valid;
        logic       last;
        logic [7:0] data;
    } mac_beat_t;

    // Transmit request, payload_len includes the index bytes
    typedef struct packed {
        logic        start;
        logic        is_arp;
        logic [15:0] payload_len;
    } tx_job_t;

    // Peer lookup result
    typedef struct packed {
        logic        found;
        logic [47:0] mac;
    } arp_result_t;

endpackage : frame_pkg

/* payload_fifo.sv */
`timescale 1ns/1ps

module payload_fifo #(
    parameter int DEPTH = 64,
    parameter int AW    = 6
) (
    input  logic          rgmii_clk,
    input  logic          arp_rstn,
    input  logic          wr_en,
    input  logic [7:0]    wr_data,
    input  logic          rd_en,
    output logic [7:0]    rd_data,
    output logic          empty,
    output logic [AW:0]   free
);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign free  = (AW + 1)'(DEPTH) - count;
    assign do_wr = wr_en && (count != (AW + 1)'(DEPTH));
    assign do_rd = rd_en && !empty;

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Registered read port
    always_ff @(posedge rgmii_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule : payload_fifo

/* udp_link_ctrl.sv */
`timescale 1ns/1ps

module udp_link_ctrl
    import net_cfg_pkg::*, frame_pkg::*;
(
    input  logic             rgmii_clk,
    input  logic             arp_rstn,
    input  logic             trig,
    input  logic [15:0]      index,
    input  logic             tx_valid,
    input  logic [7:0]       tx_data,
    input  logic [15:0]      tx_data_len,
    input  arp_result_t      arp,
    input  logic             busy,
    input  logic [FIFO_AW:0] fifo_free,
    output logic             tx_read_en,
    output logic             connected,
    output tx_job_t          job,
    output logic             fifo_wr_en,
    output logic [7:0]       fifo_wr_data
);

    typedef enum logic [2:0] {
        LINK_WAIT,
        ARP_REQ,
        ARP_WAIT,
        IDLE,
        IDX_HI,
        IDX_LO,
        DATA_RD
    } state_t;

    state_t      state;
    logic [15:0] cnt;
    logic [15:0] len_q;
    logic [7:0]  idx_lo_q;
    logic        read_active;
    logic        accept;

    assign accept = (state == IDLE) && trig && !busy;

    // Source is held off as soon as the buffer gets tight
    assign tx_read_en = read_active && (fifo_free >= READ_MARGIN);

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            state       <= LINK_WAIT;
            cnt         <= '0;
            connected   <= 1'b0;
            job         <= '0;
            fifo_wr_en  <= 1'b0;
            read_active <= 1'b0;
        end else begin
            job.start  <= 1'b0;
            fifo_wr_en <= 1'b0;
            case (state)
                LINK_WAIT: begin
                    if (cnt == LINK_WAIT_CYCLES - 16'd1) begin
                        cnt   <= '0;
                        state <= ARP_REQ;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                ARP_REQ: begin
                    job   <= '{start: 1'b1, is_arp: 1'b1, payload_len: 16'd0};
                    state <= ARP_WAIT;
                end
                ARP_WAIT: begin
                    if (arp.found) begin
                        connected <= 1'b1;
                        state     <= IDLE;
                    end else if (cnt == ARP_TIMEOUT_CYCLES - 16'd1) begin
                        // No reply, start over
                        cnt   <= '0;
                        state <= LINK_WAIT;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                IDLE: begin
                    if (accept) begin
                        job <= '{start: 1'b1, is_arp: 1'b0,
                                 payload_len: tx_data_len + INDEX_BYTES};
                        fifo_wr_en <= 1'b1;
                        state      <= IDX_HI;
                    end
                end
                IDX_HI: begin
                    fifo_wr_en <= 1'b1;
                    cnt        <= '0;
                    state      <= IDX_LO;
                end
                IDX_LO: begin
                    if (len_q != 16'd0) begin
                        read_active <= 1'b1;
                        state       <= DATA_RD;
                    end else begin
                        state <= IDLE;
                    end
                end
                DATA_RD: begin
                    fifo_wr_en <= tx_valid;
                    if (tx_valid) begin
                        cnt <= cnt + 16'd1;
                        if (cnt == len_q - 16'd1) begin
                            read_active <= 1'b0;
                            state       <= IDLE;
                        end
                    end
                end
                default: state <= LINK_WAIT;
            endcase
        end
    end

    always_ff @(posedge rgmii_clk) begin
        if (accept) begin
            idx_lo_q <= index[7:0];
            len_q    <= tx_data_len;
        end
        // Index high byte goes first
        if (accept) begin
            fifo_wr_data <= index[15:8];
        end else if (state == IDX_HI) begin
            fifo_wr_data <= idx_lo_q;
        end else begin
            fifo_wr_data <= tx_data;
        end
    end

endmodule : udp_link_ctrl

/* frame_tx.sv */
`timescale 1ns/1ps

module frame_tx
    import net_cfg_pkg::*, frame_pkg::*;
(
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  tx_job_t     job,
    input  arp_result_t peer,
    input  logic [7:0]  fifo_rd_data,
    input  logic        fifo_empty,
    output logic        fifo_rd_en,
    output logic        busy,
    output mac_beat_t   mac_tx
);

    logic                         is_arp_q;
    logic [15:0]                  len_q;
    logic [15:0]                  cnt;
    logic [15:0]                  total;
    logic [15:0]                  ip_len;
    logic [15:0]                  udp_len;
    logic [UDP_HDR_BYTES*8-1:0]   hdr;
    logic [7:0]                   hdr_byte;
    logic [7:0]                   first_byte;
    logic                         in_hdr;
    mac_beat_t                    hdr_beat;
    logic                         pop_q;
    logic                         pop_last_q;

    assign total   = is_arp_q ? ARP_FRAME_BYTES : UDP_HDR_BYTES + len_q;
    assign ip_len  = 16'd28 + len_q;
    assign udp_len = 16'd8 + len_q;
    assign in_hdr  = cnt < UDP_HDR_BYTES;

    // Whole header as one vector, byte 0 at the top
    always_comb begin
        if (is_arp_q) begin
            hdr = {48'hFFFF_FFFF_FFFF, LOCAL_MAC, 16'h0806,
                   16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0001,
                   LOCAL_MAC, LOCAL_IP, 48'h0, DEST_IP};
        end else begin
            hdr = {peer.mac, LOCAL_MAC, 16'h0800,
                   8'h45, 8'h00, ip_len, 16'h0000, 16'h4000, 8'h40, 8'h11, 16'h0000,
                   LOCAL_IP, DEST_IP,
                   LOCAL_PORT, DEST_PORT, udp_len, 16'h0000};
        end
    end

    assign hdr_byte   = hdr[(UDP_HDR_BYTES - 16'd1 - cnt) * 8 +: 8];
    assign first_byte = job.is_arp ? 8'hFF : peer.mac[47:40];

    assign fifo_rd_en = busy && !is_arp_q && !in_hdr && (cnt < total) && !fifo_empty;

    // Popped byte goes straight out on the cycle its data arrives
    always_comb begin
        if (pop_q) begin
            mac_tx.valid = 1'b1;
            mac_tx.last  = pop_last_q;
            mac_tx.data  = fifo_rd_data;
        end else begin
            mac_tx = hdr_beat;
        end
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            busy       <= 1'b0;
            is_arp_q   <= 1'b0;
            len_q      <= '0;
            cnt        <= '0;
            hdr_beat   <= '0;
            pop_q      <= 1'b0;
            pop_last_q <= 1'b0;
        end else begin
            hdr_beat.valid <= 1'b0;
            hdr_beat.last  <= 1'b0;
            pop_q          <= fifo_rd_en;
            pop_last_q     <= fifo_rd_en && (cnt == total - 16'd1);
            if (!busy) begin
                if (job.start) begin
                    busy           <= 1'b1;
                    is_arp_q       <= job.is_arp;
                    len_q          <= job.payload_len;
                    cnt            <= 16'd1;
                    hdr_beat.valid <= 1'b1;
                    hdr_beat.data  <= first_byte;
                end
            end else if (mac_tx.valid && mac_tx.last) begin
                busy <= 1'b0;
            end else if (in_hdr) begin
                hdr_beat.valid <= 1'b1;
                hdr_beat.last  <= (cnt == total - 16'd1);
                hdr_beat.data  <= hdr_byte;
                cnt            <= cnt + 16'd1;
            end else if (fifo_rd_en) begin
                cnt <= cnt + 16'd1;
            end
        end
    end

endmodule : frame_tx

/* arp_rx.sv */
`timescale 1ns/1ps

module arp_rx
    import net_cfg_pkg::*, frame_pkg::*;
(
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  mac_beat_t   mac_rx,
    output arp_result_t arp
);

    logic [5:0]  cnt;
    logic        bad;
    logic        mism;
    logic        accept;
    logic        found_q;
    logic [47:0] cand_mac;
    logic [47:0] mac_q;

    assign arp = '{found: found_q, mac: mac_q};

    // Ethertype, opcode and sender IP
    always_comb begin
        case (cnt)
            6'd12:   mism = mac_rx.data != 8'h08;
            6'd13:   mism = mac_rx.data != 8'h06;
            6'd20:   mism = mac_rx.data != 8'h00;
            6'd21:   mism = mac_rx.data != 8'h02;
            6'd28:   mism = mac_rx.data != DEST_IP[31:24];
            6'd29:   mism = mac_rx.data != DEST_IP[23:16];
            6'd30:   mism = mac_rx.data != DEST_IP[15:8];
            6'd31:   mism = mac_rx.data != DEST_IP[7:0];
            default: mism = 1'b0;
        endcase
    end

    assign accept = mac_rx.valid && mac_rx.last && !bad && (cnt >= 6'd41);

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            cnt     <= '0;
            bad     <= 1'b0;
            found_q <= 1'b0;
        end else begin
            found_q <= accept;
            if (mac_rx.valid) begin
                bad <= ((cnt == 6'd0) ? 1'b0 : bad) | mism;
                if (mac_rx.last) begin
                    cnt <= '0;
                end else if (cnt != 6'd63) begin
                    cnt <= cnt + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge rgmii_clk) begin
        // Sender MAC sits in bytes 22 to 27
        if (mac_rx.valid && (cnt >= 6'd22) && (cnt <= 6'd27)) begin
            cand_mac <= {cand_mac[39:0], mac_rx.data};
        end
        if (accept) begin
            mac_q <= cand_mac;
        end
    end

endmodule : arp_rx

/* udp_packet.sv */
`timescale 1ns/1ps

module udp_packet
    import net_cfg_pkg::*, frame_pkg::*;
(
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  logic        trig,
    input  logic [15:0] index,
    input  logic        tx_valid,
    input  logic [7:0]  tx_data,
    input  logic [15:0] tx_data_len,
    input  mac_beat_t   mac_rx,
    output logic        tx_read_en,
    output logic        connected,
    output mac_beat_t   mac_tx
);

    tx_job_t          job;
    arp_result_t      arp;
    logic             busy;
    logic             fifo_wr_en;
    logic [7:0]       fifo_wr_data;
    logic             fifo_rd_en;
    logic [7:0]       fifo_rd_data;
    logic             fifo_empty;
    logic [FIFO_AW:0] fifo_free;

    udp_link_ctrl i_link_ctrl (
        .rgmii_clk    (rgmii_clk),
        .arp_rstn     (arp_rstn),
        .trig         (trig),
        .index        (index),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .tx_data_len  (tx_data_len),
        .arp          (arp),
        .busy         (busy),
        .fifo_free    (fifo_free),
        .tx_read_en   (tx_read_en),
        .connected    (connected),
        .job          (job),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data)
    );

    payload_fifo #(
        .DEPTH (FIFO_DEPTH),
        .AW    (FIFO_AW)
    ) i_payload_fifo (
        .rgmii_clk (rgmii_clk),
        .arp_rstn  (arp_rstn),
        .wr_en     (fifo_wr_en),
        .wr_data   (fifo_wr_data),
        .rd_en     (fifo_rd_en),
        .rd_data   (fifo_rd_data),
        .empty     (fifo_empty),
        .free      (fifo_free)
    );

    frame_tx i_frame_tx (
        .rgmii_clk    (rgmii_clk),
        .arp_rstn     (arp_rstn),
        .job          (job),
        .peer         (arp),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (fifo_rd_en),
        .busy         (busy),
        .mac_tx       (mac_tx)
    );

    arp_rx i_arp_rx (
        .rgmii_clk (rgmii_clk),
        .arp_rstn  (arp_rstn),
        .mac_rx    (mac_rx),
        .arp       (arp)
    );

endmodule : udp_packet

/* udp_packet_asserts.sv */
`timescale 1ns/1ps

module udp_packet_asserts
    import net_cfg_pkg::*, frame_pkg::*;
(
    input logic             rgmii_clk,
    input logic             arp_rstn,
    input logic             tx_read_en,
    input logic             connected,
    input mac_beat_t        mac_tx,
    input tx_job_t          job,
    input logic             fifo_wr_en,
    input logic             fifo_rd_en,
    input logic [FIFO_AW:0] fifo_free,
    input arp_result_t      arp
);

    int fail_count = 0;

    // Everything quiet while reset is held
    assert property (@(posedge rgmii_clk)
        !arp_rstn |-> !tx_read_en && !connected && !job.start && !fifo_wr_en
                      && !fifo_rd_en && !mac_tx.valid && !arp.found)
    else begin
        fail_count++;
        $error("control output active during reset");
    end

    assert property (@(posedge rgmii_clk) disable iff (!arp_rstn) !$fell(connected))
    else begin
        fail_count++;
        $error("connected dropped after link-up");
    end

    assert property (@(posedge rgmii_clk) disable iff (!arp_rstn) mac_tx.last |-> mac_tx.valid)
    else begin
        fail_count++;
        $error("mac_tx last without valid");
    end

    assert property (@(posedge rgmii_clk) disable iff (!arp_rstn) tx_read_en |-> connected)
    else begin
        fail_count++;
        $error("source read before link-up");
    end

    // Write into a full buffer would lose a byte
    assert property (@(posedge rgmii_clk) disable iff (!arp_rstn)
        fifo_wr_en |-> fifo_free != '0)
    else begin
        fail_count++;
        $error("payload FIFO written while full");
    end

endmodule : udp_packet_asserts

bind udp_packet udp_packet_asserts i_asserts (
    .rgmii_clk  (rgmii_clk),
    .arp_rstn   (arp_rstn),
    .tx_read_en (tx_read_en),
    .connected  (connected),
    .mac_tx     (mac_tx),
    .job        (job),
    .fifo_wr_en (fifo_wr_en),
    .fifo_rd_en (fifo_rd_en),
    .fifo_free  (fifo_free),
    .arp        (arp)
);

/* tb_udp_packet.sv */
`timescale 1ns/1ps

module tb_udp_packet
    import net_cfg_pkg::*, frame_pkg::*;
();

    localparam int MAX_DATA  = 128;
    localparam int RUN_LIMIT = 4 * (int'(LINK_WAIT_CYCLES) + int'(ARP_TIMEOUT_CYCLES))
                             + 2 * (2 * int'(ARP_FRAME_BYTES)
                             + 4 * (int'(UDP_HDR_BYTES) + int'(INDEX_BYTES) + MAX_DATA));
    localparam logic [47:0] PEER_MAC  = 48'h02_A4_5C_33_19_E7;
    localparam logic [47:0] STRAY_MAC = 48'h02_00_00_00_0B_AD;
    localparam logic [31:0] STRAY_IP  = 32'hC0_A8_01_4D;

    logic        rgmii_clk;
    logic        arp_rstn;
    logic        trig;
    logic [15:0] index;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic [15:0] tx_data_len;
    mac_beat_t   mac_rx;
    logic        tx_read_en;
    logic        connected;
    mac_beat_t   mac_tx;

    logic [31:0] lfsr = 32'had0e_fe06;
    logic [7:0]  scratch[$];
    logic [7:0]  exp_frame[$];
    logic [7:0]  src_bytes[$];
    int          src_pos = 0;
    int          byte_idx = 0;
    int          frames_seen = 0;
    int          frame_errs = 0;
    int          ctrl_errs = 0;
    int          cycles = 0;
    logic        gaps_on = 1'b0;
    logic        conn_allowed = 1'b0;
    logic        read_forbid = 1'b0;
    logic        read_en_seen = 1'b0;

    initial rgmii_clk = 1'b0;
    always #5 rgmii_clk = ~rgmii_clk;

    udp_packet i_udp_packet (
        .rgmii_clk   (rgmii_clk),
        .arp_rstn    (arp_rstn),
        .trig        (trig),
        .index       (index),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_data_len (tx_data_len),
        .mac_rx      (mac_rx),
        .tx_read_en  (tx_read_en),
        .connected   (connected),
        .mac_tx      (mac_tx)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic push_field(input logic [63:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            scratch.push_back(v[i*8 +: 8]);
        end
    endtask

    task automatic build_arp_request();
        scratch.delete();
        push_field(48'hFFFF_FFFF_FFFF, 6);
        push_field(LOCAL_MAC, 6);
        push_field(16'h0806, 2);
        push_field(16'h0001, 2);
        push_field(16'h0800, 2);
        push_field(16'h0604, 2);
        push_field(16'h0001, 2);
        push_field(LOCAL_MAC, 6);
        push_field(LOCAL_IP, 4);
        push_field(48'h0, 6);
        push_field(DEST_IP, 4);
    endtask

    task automatic build_arp_reply(input logic [47:0] mac, input logic [31:0] ip);
        scratch.delete();
        push_field(LOCAL_MAC, 6);
        push_field(mac, 6);
        push_field(32'h0806_0001, 4);
        push_field(32'h0800_0604, 4);
        push_field(16'h0002, 2);
        push_field(mac, 6);
        push_field(ip, 4);
        push_field(LOCAL_MAC, 6);
        push_field(LOCAL_IP, 4);
    endtask

    task automatic build_udp_frame(input logic [47:0] mac, input logic [15:0] idx, input int n);
        scratch.delete();
        push_field(mac, 6);
        push_field(LOCAL_MAC, 6);
        push_field(32'h0800_4500, 4);
        push_field(30 + n, 2);
        push_field(32'h0000_4000, 4);
        push_field(32'h4011_0000, 4);
        push_field(LOCAL_IP, 4);
        push_field(DEST_IP, 4);
        push_field(LOCAL_PORT, 2);
        push_field(DEST_PORT, 2);
        push_field(10 + n, 2);
        push_field(16'h0000, 2);
        push_field(idx, 2);
        foreach (src_bytes[i]) begin
            scratch.push_back(src_bytes[i]);
        end
    endtask

    task automatic make_source(input int n);
        src_bytes.delete();
        src_pos = 0;
        for (int i = 0; i < n; i++) begin
            src_bytes.push_back(8'(i) + 8'(take_bits(8)));
        end
    endtask

    // Peer side of mac_rx
    task automatic send_frame();
        foreach (scratch[i]) begin
            @(posedge rgmii_clk);
            #1;
            mac_rx.valid = 1'b1;
            mac_rx.last  = (i == scratch.size() - 1);
            mac_rx.data  = scratch[i];
        end
        @(posedge rgmii_clk);
        #1;
        mac_rx = '0;
    endtask

    task automatic wait_frames(input int target);
        while (frames_seen < target) begin
            @(posedge rgmii_clk);
        end
    endtask

    task automatic send_udp(input logic [15:0] idx, input int n, input logic gaps,
                            input logic retrig);
        int target;
        target = frames_seen + 1;
        make_source(n);
        build_udp_frame(PEER_MAC, idx, n);
        exp_frame = scratch;
        gaps_on   = gaps;
        @(posedge rgmii_clk);
        #1;
        trig        = 1'b1;
        index       = idx;
        tx_data_len = n[15:0];
        @(posedge rgmii_clk);
        #1;
        trig = 1'b0;
        if (retrig) begin
            // Controller is idle again here while the frame is still on mac_tx
            repeat (20) @(posedge rgmii_clk);
            #1;
            trig  = 1'b1;
            index = ~idx;
            @(posedge rgmii_clk);
            #1;
            trig        = 1'b0;
            read_forbid = 1'b1;
        end
        wait_frames(target);
        repeat (100) @(posedge rgmii_clk);
        assert (frames_seen == target) else begin
            ctrl_errs++;
            $display("Fail at %0t: frames_seen expected %0d got %0d", $time, target, frames_seen);
        end
        if (retrig) begin
            read_forbid = 1'b0;
        end
    endtask

    task automatic report_and_finish(input logic timed_out);
        int sva_errs;
        sva_errs = i_udp_packet.i_asserts.fail_count;
        $display("Errors: %0d frame, %0d control, %0d assertion%s", frame_errs, ctrl_errs,
                 sva_errs, timed_out ? ", run timed out" : "");
        if (!timed_out && frame_errs == 0 && ctrl_errs == 0 && sva_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // Frame checker
    always @(negedge rgmii_clk) begin
        if (arp_rstn && mac_tx.valid) begin
            assert (byte_idx < exp_frame.size()) else begin
                frame_errs++;
                $display("Frame on mac_tx runs past the %0d bytes expected", exp_frame.size());
            end
            if (byte_idx < exp_frame.size()) begin
                assert (mac_tx.data == exp_frame[byte_idx]) else begin
                    frame_errs++;
                    $display("Fail at %0t: mac_tx.data[%0d] expected %02h got %02h", $time,
                             byte_idx, exp_frame[byte_idx], mac_tx.data);
                end
                assert (mac_tx.last == (byte_idx == exp_frame.size() - 1)) else begin
                    frame_errs++;
                    $display("Fail at %0t: mac_tx.last[%0d] expected %0b got %0b", $time,
                             byte_idx, byte_idx == exp_frame.size() - 1, mac_tx.last);
                end
            end
            if (mac_tx.last) begin
                frames_seen++;
                byte_idx = 0;
            end else begin
                byte_idx++;
            end
        end
    end

    always @(negedge rgmii_clk) begin
        if (arp_rstn) begin
            assert (conn_allowed || !connected) else begin
                ctrl_errs++;
                $display("Fail at %0t: connected expected 0 got 1", $time);
            end
            assert (!(read_forbid && tx_read_en)) else begin
                ctrl_errs++;
                $display("Fail at %0t: tx_read_en expected 0 got 1", $time);
            end
        end
        read_en_seen = tx_read_en;
    end

    // Data source answers the level seen in the previous cycle
    always @(posedge rgmii_clk) begin
        #1;
        if (read_en_seen && src_pos < src_bytes.size() && (!gaps_on || take_bits(1) == 1)) begin
            tx_valid = 1'b1;
            tx_data  = src_bytes[src_pos];
            src_pos++;
        end else begin
            tx_valid = 1'b0;
        end
    end

    always @(posedge rgmii_clk) begin
        cycles++;
        if (cycles == RUN_LIMIT) begin
            $display("Run stopped at cycle limit %0d before all frames arrived", RUN_LIMIT);
            report_and_finish(1'b1);
        end
    end

    initial begin
        arp_rstn    = 1'b0;
        trig        = 1'b0;
        index       = '0;
        tx_valid    = 1'b0;
        tx_data     = '0;
        tx_data_len = '0;
        mac_rx      = '0;
        build_arp_request();
        exp_frame = scratch;
        repeat (16) @(posedge rgmii_clk);
        #1;
        arp_rstn = 1'b1;

        // Two requests with no reply in between
        wait_frames(2);
        build_arp_reply(STRAY_MAC, STRAY_IP);
        send_frame();
        repeat (4) @(posedge rgmii_clk);
        conn_allowed = 1'b1;
        build_arp_reply(PEER_MAC, DEST_IP);
        send_frame();
        while (!connected) begin
            @(posedge rgmii_clk);
        end

        send_udp(16'(take_bits(16)), 1 + int'(take_bits(5)), 1'b0, 1'b0);
        send_udp(16'(take_bits(16)), 65 + int'(take_bits(6)), 1'b1, 1'b0);
        read_forbid = 1'b1;
        send_udp(16'(take_bits(16)), 0, 1'b0, 1'b0);
        read_forbid = 1'b0;
        send_udp(16'(take_bits(16)), 8, 1'b0, 1'b1);
        report_and_finish(1'b0);
    end

endmodule : tb_udp_packet

/* filelist.f */
net_cfg_pkg.sv
frame_pkg.sv
payload_fifo.sv
udp_link_ctrl.sv
frame_tx.sv
arp_rx.sv
udp_packet.sv
udp_packet_asserts.sv
tb_udp_packet.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_udp_packet -o sim_udp_packet
./obj_dir/sim_udp_packet +verilator+error+limit+1000 | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
